// ==== verilog.f ====
verilog/bus_pkg.sv
verilog/mem_sram.sv
verilog/uart_tx.sv
verilog/clint_timer.sv
verilog/bus_arbiter.sv
verilog/soc_bus_top.sv
test/tb_soc_bus.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the bus testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_soc_bus -Mdir obj_dir -f verilog.f
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

out=$(./obj_dir/Vtb_soc_bus)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "All tests passed"; then
  exit 0
fi
exit 1

// ==== test/tb_soc_bus.sv ====
`timescale 1ns/1ps

module tb_soc_bus;
  import bus_pkg::*;

  localparam int req_limit = 100;
  localparam int frame_clks = 10 * clks_per_bit;
  localparam int n_words = 16;
  localparam int n_rand = 24;
  // stores, loads, fetches and timer reads over all tests
  localparam int n_reqs = 2 * n_words + 4 + 4 + 4 + 2 + 4 + 2 * n_rand;
  localparam int budget_cycles = n_reqs * req_limit + 3 * frame_clks + 20;

  logic              clk;
  logic              rst;
  logic [addr_w-1:0] ifu_araddr_i;
  logic              ifu_arvalid_i;
  logic [data_w-1:0] ifu_rdata_o;
  logic              ifu_rvalid_o;
  logic [addr_w-1:0] lsu_araddr_i;
  logic              lsu_arvalid_i;
  logic [data_w-1:0] lsu_rdata_o;
  logic              lsu_rvalid_o;
  logic [addr_w-1:0] lsu_awaddr_i;
  logic [data_w-1:0] lsu_wdata_i;
  logic [strb_w-1:0] lsu_wstrb_i;
  logic              lsu_wvalid_i;
  logic              lsu_wready_o;
  logic              tx_o;

  logic [data_w-1:0] model [n_words];
  logic [15:0]       lfsr_q;
  logic [data_w-1:0] cyc;
  int                errors;
  int                timeouts;

  soc_bus_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // counts like mtime from the first edge out of reset
  always @(posedge clk) begin
    if (rst) begin
      cyc <= '0;
    end else begin
      cyc <= cyc + 1'b1;
    end
  end

  initial begin
    repeat (budget_cycles) @(posedge clk);
    $display("Watchdog: run did not finish within %0d cycles", budget_cycles);
    $display("Some tests failed");
    $finish;
  end

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hb400) : (lfsr_q >> 1);
    end
    return r;
  endfunction

  function automatic logic [addr_w-1:0] word_addr(input int idx);
    return sram_base + addr_w'(idx * 4);
  endfunction

  task automatic value_error(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    errors++;
    $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
  endtask

  // raises a store and holds it until lsu_wready_o
  task automatic store(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
                       input logic [strb_w-1:0] strb);
    int n;
    lsu_awaddr_i = addr;
    lsu_wdata_i  = data;
    lsu_wstrb_i  = strb;
    lsu_wvalid_i = 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (ifu_rvalid_o || lsu_rvalid_o) begin
        errors++;
        $display("Read strobe fired during a store to %h", addr);
      end
    end while (!lsu_wready_o && n < req_limit);
    if (!lsu_wready_o) begin
      timeouts++;
      $display("Store to %h never got lsu_wready_o", addr);
    end
    lsu_wvalid_i = 1'b0;
  endtask

  task automatic sram_store(input int idx, input logic [data_w-1:0] data,
                            input logic [strb_w-1:0] strb);
    store(word_addr(idx), data, strb);
    for (int i = 0; i < strb_w; i++) begin
      if (strb[i]) begin
        model[idx][8*i +: 8] = data[8*i +: 8];
      end
    end
  endtask

  // fetch or load while the other read strobe stays quiet
  task automatic read(input bit fetch, input logic [addr_w-1:0] addr,
                      output logic [data_w-1:0] data);
    int n;
    bit got;
    got = 1'b0;
    data = 'x;
    if (fetch) begin
      ifu_araddr_i  = addr;
      ifu_arvalid_i = 1'b1;
    end else begin
      lsu_araddr_i  = addr;
      lsu_arvalid_i = 1'b1;
    end
    n = 0;
    while (!got && n < req_limit) begin
      @(negedge clk);
      n++;
      if ((fetch ? lsu_rvalid_o : ifu_rvalid_o) || lsu_wready_o) begin
        errors++;
        $display("Wrong response strobe during a read of %h", addr);
      end
      if (fetch ? ifu_rvalid_o : lsu_rvalid_o) begin
        got = 1'b1;
        data = fetch ? ifu_rdata_o : lsu_rdata_o;
      end
    end
    if (!got) begin
      timeouts++;
      $display("Read of %h never got its response strobe", addr);
    end
    ifu_arvalid_i = 1'b0;
    lsu_arvalid_i = 1'b0;
  endtask

  task automatic sram_lane_traffic;
    logic [data_w-1:0] got;
    for (int i = 0; i < n_words; i++) begin
      sram_store(i, (32'h0101_0101 * data_w'(i)) ^ 32'hc3a5_0f96, 4'b1111);
    end
    // one lane at a time
    for (int i = 0; i < strb_w; i++) begin
      sram_store(i + 1, 32'hdead_beef, 4'b0001 << i);
    end
    for (int i = 0; i < n_words; i++) begin
      read(1'b0, word_addr(i), got);
      if (got !== model[i]) value_error("lsu_rdata_o", got, model[i]);
    end
  endtask

  task automatic fetch_stored_words;
    logic [data_w-1:0] got;
    for (int i = 0; i < 4; i++) begin
      read(1'b1, word_addr(3 * i + 2), got);
      if (got !== model[3 * i + 2]) value_error("ifu_rdata_o", got, model[3 * i + 2]);
    end
  endtask

  // load raised load_delay cycles after the fetch
  task automatic race_reads(input int fetch_idx, input int load_idx,
                            input int load_delay, input bit load_first);
    int t_ifu;
    int t_lsu;
    logic [data_w-1:0] d_ifu;
    logic [data_w-1:0] d_lsu;
    t_ifu = -1;
    t_lsu = -1;
    ifu_araddr_i  = word_addr(fetch_idx);
    ifu_arvalid_i = 1'b1;
    lsu_araddr_i  = word_addr(load_idx);
    lsu_arvalid_i = (load_delay == 0);
    for (int n = 1; n <= 2 * req_limit && (t_ifu < 0 || t_lsu < 0); n++) begin
      @(negedge clk);
      if (ifu_rvalid_o) begin
        t_ifu = n;
        d_ifu = ifu_rdata_o;
        ifu_arvalid_i = 1'b0;
      end
      if (lsu_rvalid_o) begin
        t_lsu = n;
        d_lsu = lsu_rdata_o;
        lsu_arvalid_i = 1'b0;
      end
      if (n == load_delay) lsu_arvalid_i = 1'b1;
    end
    ifu_arvalid_i = 1'b0;
    lsu_arvalid_i = 1'b0;
    if (t_ifu < 0 || t_lsu < 0) begin
      timeouts++;
      $display("Competing fetch and load did not both complete");
    end else begin
      if ((t_lsu < t_ifu) != load_first) begin
        errors++;
        $display("Fetch and load completed in the wrong order");
      end
      if (d_ifu !== model[fetch_idx]) value_error("ifu_rdata_o", d_ifu, model[fetch_idx]);
      if (d_lsu !== model[load_idx]) value_error("lsu_rdata_o", d_lsu, model[load_idx]);
    end
  endtask

  // start bit, data lsb first and stop bit sampled near mid-bit
  task automatic check_frame(input logic [7:0] data);
    int n;
    logic [9:0] bits;
    bits = {1'b1, data, 1'b0};
    n = 0;
    while (tx_o !== 1'b0 && n < req_limit) begin
      @(negedge clk);
      n++;
    end
    if (tx_o !== 1'b0) begin
      timeouts++;
      $display("No start bit appeared on tx_o");
    end else begin
      repeat (clks_per_bit / 2) @(negedge clk);
      for (int b = 0; b < 10; b++) begin
        if (tx_o !== bits[b]) value_error("tx_o", data_w'(tx_o), data_w'(bits[b]));
        if (b < 9) repeat (clks_per_bit) @(negedge clk);
      end
    end
  endtask

  task automatic serial_frames;
    logic [data_w-1:0] c_first;
    // upper bytes are not sent
    store(serial_addr, 32'hffff_ff5a, 4'b0001);
    c_first = cyc;
    fork
      check_frame(8'h5a);
      store(serial_addr, 32'h0000_00c3, 4'b0001);
    join
    if (cyc - c_first < frame_clks) begin
      errors++;
      $display("Second serial store finished %0d cycles after the first, before the frame ended",
               cyc - c_first);
    end
    check_frame(8'hc3);
  endtask

  task automatic timer_reads;
    logic [data_w-1:0] c0;
    logic [data_w-1:0] c1;
    logic [data_w-1:0] t0;
    logic [data_w-1:0] t1;
    logic [data_w-1:0] hi;
    c0 = cyc;
    read(1'b0, rtc_addr, t0);
    c1 = cyc;
    if (t0 < c0 || t0 > c1) begin
      errors++;
      $display("Error at %0t: lsu_rdata_o got %0d expected %0d..%0d", $time, t0, c0, c1);
    end
    read(1'b0, rtc_addr_up, hi);
    if (hi !== '0) value_error("lsu_rdata_o", hi, '0);
    read(1'b1, rtc_addr, t1);
    if (t1 <= t0) value_error("ifu_rdata_o", t1, t0 + 1);
    read(1'b0, rtc_addr, t0);
    if (t0 <= t1) value_error("lsu_rdata_o", t0, t1 + 1);
  endtask

  task automatic random_traffic;
    int idx;
    logic [data_w-1:0] data;
    logic [strb_w-1:0] strb;
    logic [data_w-1:0] got;
    for (int i = 0; i < n_rand; i++) begin
      idx  = int'(lfsr_bits($clog2(n_words)));
      data = lfsr_bits(data_w);
      strb = strb_w'(lfsr_bits(strb_w));
      sram_store(idx, data, strb);
      read(1'b0, word_addr(idx), got);
      if (got !== model[idx]) value_error("lsu_rdata_o", got, model[idx]);
    end
  endtask

  initial begin
    errors = 0;
    timeouts = 0;
    lfsr_q = 16'd5;
    rst = 1'b1;
    ifu_araddr_i = '0;
    ifu_arvalid_i = 1'b0;
    lsu_araddr_i = '0;
    lsu_arvalid_i = 1'b0;
    lsu_awaddr_i = '0;
    lsu_wdata_i = '0;
    lsu_wstrb_i = '0;
    lsu_wvalid_i = 1'b0;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    if (tx_o !== 1'b1) value_error("tx_o", data_w'(tx_o), 32'h1);
    sram_lane_traffic();
    fetch_stored_words();
    race_reads(2, 5, 0, 1'b1);
    // the bus needs a cycle to drop the last grant before the fetch wins it
    race_reads(7, 3, 2, 1'b0);
    serial_frames();
    timer_reads();
    random_traffic();
    $display("mismatches: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== verilog/soc_bus_top.sv ====
`timescale 1ns/1ps

module soc_bus_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [bus_pkg::addr_w-1:0]  ifu_araddr_i,
  input  logic                        ifu_arvalid_i,
  output logic [bus_pkg::data_w-1:0]  ifu_rdata_o,
  output logic                        ifu_rvalid_o,
  input  logic [bus_pkg::addr_w-1:0]  lsu_araddr_i,
  input  logic                        lsu_arvalid_i,
  output logic [bus_pkg::data_w-1:0]  lsu_rdata_o,
  output logic                        lsu_rvalid_o,
  input  logic [bus_pkg::addr_w-1:0]  lsu_awaddr_i,
  input  logic [bus_pkg::data_w-1:0]  lsu_wdata_i,
  input  logic [bus_pkg::data_w/8-1:0] lsu_wstrb_i,
  input  logic                        lsu_wvalid_i,
  output logic                        lsu_wready_o,
  output logic                        tx_o
);
  import bus_pkg::*;

  logic              sram_rd, sram_wr, sram_done;
  logic [addr_w-1:0] sram_addr;
  logic [data_w-1:0] sram_wdata, sram_rdata;
  logic [strb_w-1:0] sram_wstrb;
  logic              uart_wr, uart_done;
  logic [data_w-1:0] uart_wdata;
  logic              clint_rd, clint_hi, clint_done;
  logic [data_w-1:0] clint_rdata;

  bus_arbiter u_arbiter (
    .clk, .rst,
    .ifu_araddr_i, .ifu_arvalid_i, .ifu_rdata_o, .ifu_rvalid_o,
    .lsu_araddr_i, .lsu_arvalid_i, .lsu_rdata_o, .lsu_rvalid_o,
    .lsu_awaddr_i, .lsu_wdata_i, .lsu_wstrb_i, .lsu_wvalid_i, .lsu_wready_o,
    .sram_rd_o(sram_rd), .sram_wr_o(sram_wr), .sram_addr_o(sram_addr),
    .sram_wdata_o(sram_wdata), .sram_wstrb_o(sram_wstrb),
    .sram_rdata_i(sram_rdata), .sram_done_i(sram_done),
    .uart_wr_o(uart_wr), .uart_wdata_o(uart_wdata), .uart_done_i(uart_done),
    .clint_rd_o(clint_rd), .clint_hi_o(clint_hi),
    .clint_rdata_i(clint_rdata), .clint_done_i(clint_done)
  );

  mem_sram u_sram (
    .clk, .rst,
    .rd_i(sram_rd), .wr_i(sram_wr), .addr_i(sram_addr),
    .wdata_i(sram_wdata), .wstrb_i(sram_wstrb),
    .rdata_o(sram_rdata), .done_o(sram_done)
  );

  uart_tx u_uart (
    .clk, .rst,
    .wr_i(uart_wr), .wdata_i(uart_wdata),
    .done_o(uart_done), .tx_o
  );

  clint_timer u_clint (
    .clk, .rst,
    .rd_i(clint_rd), .hi_i(clint_hi),
    .rdata_o(clint_rdata), .done_o(clint_done)
  );

endmodule

// ==== verilog/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter (
  input  logic                        clk,
  input  logic                        rst,
  // fetch
  input  logic [bus_pkg::addr_w-1:0]  ifu_araddr_i,
  input  logic                        ifu_arvalid_i,
  output logic [bus_pkg::data_w-1:0]  ifu_rdata_o,
  output logic                        ifu_rvalid_o,
  // load
  input  logic [bus_pkg::addr_w-1:0]  lsu_araddr_i,
  input  logic                        lsu_arvalid_i,
  output logic [bus_pkg::data_w-1:0]  lsu_rdata_o,
  output logic                        lsu_rvalid_o,
  // store
  input  logic [bus_pkg::addr_w-1:0]  lsu_awaddr_i,
  input  logic [bus_pkg::data_w-1:0]  lsu_wdata_i,
  input  logic [bus_pkg::strb_w-1:0]  lsu_wstrb_i,
  input  logic                        lsu_wvalid_i,
  output logic                        lsu_wready_o,
  // sram
  output logic                        sram_rd_o,
  output logic                        sram_wr_o,
  output logic [bus_pkg::addr_w-1:0]  sram_addr_o,
  output logic [bus_pkg::data_w-1:0]  sram_wdata_o,
  output logic [bus_pkg::strb_w-1:0]  sram_wstrb_o,
  input  logic [bus_pkg::data_w-1:0]  sram_rdata_i,
  input  logic                        sram_done_i,
  // uart
  output logic                        uart_wr_o,
  output logic [bus_pkg::data_w-1:0]  uart_wdata_o,
  input  logic                        uart_done_i,
  // clint
  output logic                        clint_rd_o,
  output logic                        clint_hi_o,
  input  logic [bus_pkg::data_w-1:0]  clint_rdata_i,
  input  logic                        clint_done_i
);
  import bus_pkg::*;

  grant_t            grant_q;
  grant_t            grant_d;
  target_t           target;
  logic [addr_w-1:0] owner_addr;
  logic [data_w-1:0] rd_data;
  logic              is_wr;
  logic              is_rd;
  logic              tgt_done;

  // loads and stores beat fetches out of idle
  always_comb begin
    grant_d = grant_q;
    if (grant_q == grant_idle) begin
      if (lsu_wvalid_i) begin
        grant_d = grant_lsu_wr;
      end else if (lsu_arvalid_i) begin
        grant_d = grant_lsu_rd;
      end else if (ifu_arvalid_i) begin
        grant_d = grant_ifu_rd;
      end
    end else if (tgt_done) begin
      grant_d = grant_idle;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      grant_q <= grant_idle;
    end else begin
      grant_q <= grant_d;
    end
  end

  // address of whoever owns the bus
  always_comb begin
    case (grant_q)
      grant_ifu_rd: owner_addr = ifu_araddr_i;
      grant_lsu_rd: owner_addr = lsu_araddr_i;
      grant_lsu_wr: owner_addr = lsu_awaddr_i;
      default:      owner_addr = '0;
    endcase
  end

  assign is_wr = (grant_q == grant_lsu_wr);
  assign is_rd = (grant_q == grant_ifu_rd) || (grant_q == grant_lsu_rd);

  // decode, sram catches everything unmapped
  always_comb begin
    if (is_wr && owner_addr == serial_addr) begin
      target = tgt_uart;
    end else if (is_rd && (owner_addr == rtc_addr || owner_addr == rtc_addr_up)) begin
      target = tgt_clint;
    end else begin
      target = tgt_sram;
    end
  end

  // commands held for the whole grant
  assign sram_rd_o    = is_rd && (target == tgt_sram);
  assign sram_wr_o    = is_wr && (target == tgt_sram);
  assign sram_addr_o  = owner_addr;
  assign sram_wdata_o = lsu_wdata_i;
  assign sram_wstrb_o = sram_wr_o ? lsu_wstrb_i : '0;
  assign uart_wr_o    = is_wr && (target == tgt_uart);
  assign uart_wdata_o = lsu_wdata_i;
  assign clint_rd_o   = is_rd && (target == tgt_clint);
  assign clint_hi_o   = clint_rd_o && (owner_addr == rtc_addr_up);

  always_comb begin
    case (target)
      tgt_uart:  tgt_done = uart_done_i;
      tgt_clint: tgt_done = clint_done_i;
      default:   tgt_done = sram_done_i;
    endcase
  end

  assign rd_data = (target == tgt_clint) ? clint_rdata_i : sram_rdata_i;

  // response back to the owner in the done cycle
  assign ifu_rvalid_o = (grant_q == grant_ifu_rd) && tgt_done;
  assign lsu_rvalid_o = (grant_q == grant_lsu_rd) && tgt_done;
  assign lsu_wready_o = (grant_q == grant_lsu_wr) && tgt_done;
  assign ifu_rdata_o  = {data_w{ifu_rvalid_o}} & rd_data;
  assign lsu_rdata_o  = {data_w{lsu_rvalid_o}} & rd_data;

  a_one_target: assert property (@(posedge clk) disable iff (rst)
    $onehot0({sram_rd_o, sram_wr_o, uart_wr_o, clint_rd_o}))
    else $error("more than one target command active");

  // targets only complete while a grant is open
  a_no_idle_resp: assert property (@(posedge clk) disable iff (rst)
    (grant_q == grant_idle) |-> !(sram_done_i || uart_done_i || clint_done_i))
    else $error("target response while bus idle");

endmodule

// ==== verilog/clint_timer.sv ====
`timescale 1ns/1ps

module clint_timer (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        rd_i,
  input  logic                        hi_i,
  output logic [bus_pkg::data_w-1:0]  rdata_o,
  output logic                        done_o
);
  import bus_pkg::*;

  logic [63:0] mtime;

  // free running since reset
  always_ff @(posedge clk) begin
    if (rst) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  // one-cycle answer, guarded so a held command reads once
  always_ff @(posedge clk) begin
    if (rst) begin
      done_o <= 1'b0;
    end else begin
      done_o <= rd_i && !done_o;
    end
  end

  // mtime as seen on the accepting edge
  always_ff @(posedge clk) begin
    if (rd_i && !done_o) begin
      if (hi_i) begin
        rdata_o <= mtime[63:32];
      end else begin
        rdata_o <= mtime[data_w-1:0];
      end
    end
  end

  a_done_pulse: assert property (@(posedge clk) disable iff (rst)
    done_o |=> !done_o)
    else $error("clint done held for two cycles");

endmodule

// ==== verilog/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        wr_i,
  input  logic [bus_pkg::data_w-1:0]  wdata_i,
  output logic                        done_o,
  output logic                        tx_o
);
  import bus_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_data,
    st_stop
  } uart_state_t;

  uart_state_t          state;
  logic [clk_div_w-1:0] div;
  logic [2:0]           bit_cnt;
  logic [7:0]           shreg;
  logic                 bit_end;

  assign bit_end = (div == clk_div_w'(clks_per_bit - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= st_idle;
      div     <= '0;
      bit_cnt <= '0;
      done_o  <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (state == st_idle) begin
        div <= '0;
      end else if (bit_end) begin
        div <= '0;
      end else begin
        div <= div + 1'b1;
      end
      case (state)
        st_idle: begin
          // accept only when the line is free, else the store waits
          if (wr_i && !done_o) begin
            state  <= st_start;
            done_o <= 1'b1;
          end
        end
        st_start: begin
          if (bit_end) begin
            state   <= st_data;
            bit_cnt <= '0;
          end
        end
        st_data: begin
          if (bit_end) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              state <= st_stop;
            end
          end
        end
        default: begin
          if (bit_end) begin
            state <= st_idle;
          end
        end
      endcase
    end
  end

  // byte 0 only, shifted out lsb first
  always_ff @(posedge clk) begin
    if (state == st_idle && wr_i && !done_o) begin
      shreg <= wdata_i[7:0];
    end else if (state == st_data && bit_end) begin
      shreg <= {1'b0, shreg[7:1]};
    end
  end

  always_comb begin
    case (state)
      st_start: tx_o = 1'b0;
      st_data:  tx_o = shreg[0];
      default:  tx_o = 1'b1;
    endcase
  end

endmodule

// ==== verilog/mem_sram.sv ====
`timescale 1ns/1ps

module mem_sram (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        rd_i,
  input  logic                        wr_i,
  input  logic [bus_pkg::addr_w-1:0]  addr_i,
  input  logic [bus_pkg::data_w-1:0]  wdata_i,
  input  logic [bus_pkg::strb_w-1:0]  wstrb_i,
  output logic [bus_pkg::data_w-1:0]  rdata_o,
  output logic                        done_o
);
  import bus_pkg::*;

  logic [data_w-1:0]     mem [sram_words];
  logic [addr_w-1:0]     offset;
  logic [sram_idx_w-1:0] idx;
  logic [19:0]           lfsr;
  logic                  ready;
  logic                  busy;
  logic                  start;
  logic                  fire;

  // byte offset into the window, then word index
  assign offset = addr_i - sram_base;
  assign idx    = offset[sram_idx_w+1:2];

  // x^20 + x^17 + 1
  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr <= 20'h1;
    end else begin
      lfsr <= {lfsr[18:0], lfsr[19] ^ lfsr[16]};
    end
  end

  assign ready = wait_enable ? lfsr[0] : 1'b1;

  // new command seen, or one already pending
  assign start = (rd_i || wr_i) && !busy && !done_o;
  assign fire  = (start || busy) && ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy   <= 1'b0;
      done_o <= 1'b0;
    end else begin
      done_o <= fire;
      if (fire) begin
        busy <= 1'b0;
      end else if (start) begin
        busy <= 1'b1;
      end
    end
  end

  // access happens on the completing edge
  always_ff @(posedge clk) begin
    if (fire && rd_i) begin
      rdata_o <= mem[idx];
    end
    if (fire && wr_i) begin
      for (int i = 0; i < strb_w; i++) begin
        if (wstrb_i[i]) begin
          mem[idx][8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end
    end
  end

  a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
    !(rd_i && wr_i))
    else $error("sram read and write at once");

  // the bus must hold its command until we answer
  a_cmd_held: assert property (@(posedge clk) disable iff (rst)
    busy |-> (rd_i || wr_i))
    else $error("sram command dropped before done");

endmodule

// ==== verilog/bus_pkg.sv ====
package bus_pkg;

  // bus widths
  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int strb_w = data_w / 8;

  // sram window, word addressed inside
  localparam logic [addr_w-1:0] sram_base = 32'h8000_0000;
  localparam int sram_words = 1024;
  localparam int sram_idx_w = $clog2(sram_words);

  // device registers
  localparam logic [addr_w-1:0] serial_addr = 32'ha000_03f8;
  localparam logic [addr_w-1:0] rtc_addr = 32'ha000_0048;
  localparam logic [addr_w-1:0] rtc_addr_up = 32'ha000_004c;

  // uart bit timing
  localparam int clks_per_bit = 4;
  localparam int clk_div_w = $clog2(clks_per_bit);

  // random sram wait states on/off
  localparam logic wait_enable = 1'b1;

  // owner of the bus
  typedef enum logic [1:0] {
    grant_idle,
    grant_ifu_rd,
    grant_lsu_rd,
    grant_lsu_wr
  } grant_t;

  // decoded target of the owner's address
  typedef enum logic [1:0] {
    tgt_sram,
    tgt_uart,
    tgt_clint
  } target_t;

endpackage
